//--- verilog/loopback_pkg.sv
package loopback_pkg;

  // ------------------------------------------------------------
  // memory port geometry
  // ------------------------------------------------------------
  localparam int burst_len   = 16;                  // beats per burst
  localparam int data_width  = 64;                  // memory beat width
  localparam int burst_bytes = 128;                 // address step per burst
  localparam int addr_width  = 32;                  // memory and register addresses
  localparam int reg_width   = 32;                  // register data and counters
  localparam int size_width  = 10;                  // burst-count register

  // ------------------------------------------------------------
  // register map
  // ------------------------------------------------------------
  localparam int reg_ctrl         = 0;              // go on write, status on read
  localparam int reg_size         = 1;
  localparam int reg_rd_base      = 2;
  localparam int reg_wr_base      = 3;
  localparam int reg_total_cycles = 4;
  localparam int reg_rd_cycles    = 5;
  localparam int reg_wr_cycles    = 6;
  localparam int reg_r_count      = 7;
  localparam int reg_w_count      = 8;
  localparam int reg_ar_count     = 9;
  localparam int reg_aw_count     = 10;

  localparam int ctrl_go_bit      = 0;              // write side of reg_ctrl
  localparam int status_busy_bit  = 0;              // read side of reg_ctrl
  localparam int status_done_bit  = 1;

endpackage

//--- verilog/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
  parameter int data_width      = 64,
  parameter int fifo_addr_width = 6
) (
  input  logic                      clk,
  input  logic                      resetn,
  input  logic                      push,
  input  logic [data_width-1:0]     push_data,
  input  logic                      pop,
  output logic [data_width-1:0]     pop_data,
  output logic                      empty,
  output logic                      full,
  output logic [fifo_addr_width:0]  count
);

  localparam int depth = 1 << fifo_addr_width;

  logic [data_width-1:0]      mem [0:depth-1];
  logic [fifo_addr_width-1:0] wr_ptr;
  logic [fifo_addr_width-1:0] rd_ptr;

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= push_data;
  end

  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;                    // pointers wrap at depth
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;                    // both or neither
      endcase
    end
  end

  assign pop_data = mem[rd_ptr];                    // head word shows without a pop
  assign empty    = (count == '0);
  assign full     = (count == (fifo_addr_width+1)'(depth));

  a_no_overflow: assert property (@(posedge clk) disable iff (!resetn) !(push && full));
  a_no_underflow: assert property (@(posedge clk) disable iff (!resetn) !(pop && empty));

endmodule

//--- verilog/burst_reader.sv
`timescale 1ns/1ps

module burst_reader import loopback_pkg::*; #(
  parameter int fifo_addr_width = 6
) (
  input  logic                      clk,
  input  logic                      resetn,
  input  logic                      go,
  input  logic [addr_width-1:0]     rd_base,
  input  logic [size_width-1:0]     size,
  input  logic [fifo_addr_width:0]  count,
  input  logic                      ar_ready,
  input  logic [data_width-1:0]     r_data,
  input  logic                      r_last,
  input  logic                      r_valid,
  output logic [addr_width-1:0]     ar_addr,
  output logic                      ar_valid,
  output logic                      r_ready,
  output logic                      push,
  output logic [data_width-1:0]     push_data
);

  localparam int depth = 1 << fifo_addr_width;
  localparam logic [fifo_addr_width:0] room_limit = (fifo_addr_width+1)'(depth - burst_len);

  logic [size_width-1:0] bursts_left;
  logic                  outstanding;               // a burst is being returned
  logic                  ar_fire;
  logic                  r_fire;
  logic                  has_room;

  assign ar_fire  = ar_valid && ar_ready;
  assign r_fire   = r_valid && r_ready;
  // only one burst in flight, so nothing is pending when the next one is asked for
  assign has_room = (count <= room_limit);

  // ------------------------------------------------------------
  // address channel and burst bookkeeping
  // ------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      ar_valid    <= 1'b0;
      outstanding <= 1'b0;
      bursts_left <= '0;
    end
    else if (go)
    begin
      bursts_left <= size;
    end
    else
    begin
      if (ar_fire)
      begin
        ar_valid    <= 1'b0;
        outstanding <= 1'b1;
        bursts_left <= bursts_left - 1'b1;
      end
      else if (!ar_valid && !outstanding && bursts_left != '0 && has_room)
        ar_valid <= 1'b1;
      if (r_fire && r_last)
        outstanding <= 1'b0;                        // burst fully in the buffer
    end
  end

  always_ff @(posedge clk)
  begin
    if (go)
      ar_addr <= rd_base;
    else if (ar_fire)
      ar_addr <= ar_addr + addr_width'(burst_bytes);
  end

  assign r_ready   = outstanding;
  assign push      = r_fire;                        // every accepted beat goes in
  assign push_data = r_data;

  a_ar_hold: assert property (@(posedge clk) disable iff (!resetn)
    ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr));

endmodule

//--- verilog/burst_writer.sv
`timescale 1ns/1ps

module burst_writer import loopback_pkg::*; #(
  parameter int fifo_addr_width = 6
) (
  input  logic                      clk,
  input  logic                      resetn,
  input  logic                      go,
  input  logic [addr_width-1:0]     wr_base,
  input  logic [size_width-1:0]     size,
  input  logic [fifo_addr_width:0]  count,
  input  logic [data_width-1:0]     pop_data,
  input  logic                      aw_ready,
  input  logic                      w_ready,
  input  logic                      b_valid,
  output logic                      pop,
  output logic [addr_width-1:0]     aw_addr,
  output logic                      aw_valid,
  output logic [data_width-1:0]     w_data,
  output logic                      w_last,
  output logic                      w_valid,
  output logic                      b_ready,
  output logic                      xfer_done
);

  localparam logic [1:0] s_idle = 2'd0;
  localparam logic [1:0] s_addr = 2'd1;
  localparam logic [1:0] s_data = 2'd2;
  localparam logic [1:0] s_resp = 2'd3;
  localparam int beat_width = $clog2(burst_len);

  logic [1:0]            state;
  logic [size_width-1:0] bursts_left;
  logic [beat_width-1:0] beat_cnt;
  logic                  aw_fire;
  logic                  w_fire;
  logic                  b_fire;

  assign aw_valid = (state == s_addr);
  assign w_valid  = (state == s_data);              // a whole burst is buffered here
  assign b_ready  = (state == s_resp);
  assign aw_fire  = aw_valid && aw_ready;
  assign w_fire   = w_valid && w_ready;
  assign b_fire   = b_valid && b_ready;

  assign w_data    = pop_data;
  assign w_last    = w_valid && (beat_cnt == beat_width'(burst_len - 1));
  assign pop       = w_fire;
  assign xfer_done = b_fire && (bursts_left == size_width'(1));

  // ------------------------------------------------------------
  // burst FSM
  // ------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      state       <= s_idle;
      bursts_left <= '0;
      beat_cnt    <= '0;
    end
    else
    begin
      if (go)
        bursts_left <= size;
      case (state)
        s_idle:
          if (bursts_left != '0 && count >= burst_len)
            state <= s_addr;
        s_addr:
          if (aw_fire)
          begin
            state    <= s_data;
            beat_cnt <= '0;
          end
        s_data:
          if (w_fire)
          begin
            beat_cnt <= beat_cnt + 1'b1;
            if (w_last)
              state <= s_resp;
          end
        default:
          if (b_fire)
          begin
            state       <= s_idle;
            bursts_left <= bursts_left - 1'b1;
          end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (go)
      aw_addr <= wr_base;
    else if (b_fire)
      aw_addr <= aw_addr + addr_width'(burst_bytes);  // next burst slot
  end

  // every offered beat is a word already in the buffer
  a_w_from_buffer: assert property (@(posedge clk) disable iff (!resetn)
    w_valid |-> count != '0);

endmodule

//--- verilog/perf_monitor.sv
`timescale 1ns/1ps

module perf_monitor import loopback_pkg::*; (
  input  logic                  clk,
  input  logic                  resetn,
  input  logic                  go,
  input  logic                  xfer_done,
  input  logic                  ar_valid,
  input  logic                  ar_ready,
  input  logic                  r_valid,
  input  logic                  r_ready,
  input  logic                  r_last,
  input  logic                  aw_valid,
  input  logic                  aw_ready,
  input  logic                  w_valid,
  input  logic                  w_ready,
  input  logic                  w_last,
  input  logic                  b_valid,
  input  logic                  b_ready,
  output logic [reg_width-1:0]  total_cycles,
  output logic [reg_width-1:0]  rd_cycles,
  output logic [reg_width-1:0]  wr_cycles,
  output logic [reg_width-1:0]  r_count,
  output logic [reg_width-1:0]  w_count,
  output logic [reg_width-1:0]  ar_count,
  output logic [reg_width-1:0]  aw_count
);

  logic       total_active;
  logic       rd_active;
  logic       wr_active;
  logic [3:0] rd_open;                              // read bursts still returning
  logic       wr_open;                              // w_last sent, response pending
  logic       ar_fire;
  logic       r_fire;
  logic       aw_fire;
  logic       w_fire;
  logic       b_fire;

  assign ar_fire = ar_valid && ar_ready;
  assign r_fire  = r_valid && r_ready;
  assign aw_fire = aw_valid && aw_ready;
  assign w_fire  = w_valid && w_ready;
  assign b_fire  = b_valid && b_ready;

  // ------------------------------------------------------------
  // phase flags
  // ------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      total_active <= 1'b0;
      rd_active    <= 1'b0;
      wr_active    <= 1'b0;
      rd_open      <= '0;
      wr_open      <= 1'b0;
    end
    else if (go)
    begin
      total_active <= 1'b1;
      rd_active    <= 1'b1;
      wr_active    <= 1'b0;
      rd_open      <= '0;
    end
    else
    begin
      if (xfer_done)
      begin
        total_active <= 1'b0;
        wr_active    <= 1'b0;
      end
      else if (aw_fire)
        wr_active <= 1'b1;                          // first aw opens the write phase
      if (ar_fire)
        rd_active <= 1'b1;
      else if (r_fire && r_last && rd_open == 4'd1)
        rd_active <= 1'b0;                          // reads drained
      rd_open <= rd_open + 4'(ar_fire) - 4'(r_fire && r_last);
      if (w_fire && w_last)
        wr_open <= 1'b1;
      else if (b_fire)
        wr_open <= 1'b0;
    end
  end

  // ------------------------------------------------------------
  // counters, cleared by go
  // ------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!resetn || go)
    begin
      total_cycles <= '0;
      rd_cycles    <= '0;
      wr_cycles    <= '0;
      r_count      <= '0;
      w_count      <= '0;
      ar_count     <= '0;
      aw_count     <= '0;
    end
    else
    begin
      if (total_active)
        total_cycles <= total_cycles + 1'b1;
      if (rd_active)
        rd_cycles <= rd_cycles + 1'b1;
      if (wr_active)
        wr_cycles <= wr_cycles + 1'b1;
      if (r_fire)
        r_count <= r_count + 1'b1;
      if (w_fire)
        w_count <= w_count + 1'b1;
      if (ar_fire)
        ar_count <= ar_count + 1'b1;
      if (aw_fire)
        aw_count <= aw_count + 1'b1;
    end
  end

  // a write response only answers a burst whose last beat went out
  a_b_after_wlast: assert property (@(posedge clk) disable iff (!resetn) b_fire |-> wr_open);

endmodule

//--- verilog/ctrl_regs.sv
`timescale 1ns/1ps

module ctrl_regs import loopback_pkg::*; (
  input  logic                   clk,
  input  logic                   resetn,
  input  logic [addr_width-1:0]  reg_addr,
  input  logic [reg_width-1:0]   reg_wdata,
  input  logic                   reg_wr,
  input  logic                   reg_rd,
  input  logic                   xfer_done,
  input  logic [reg_width-1:0]   total_cycles,
  input  logic [reg_width-1:0]   rd_cycles,
  input  logic [reg_width-1:0]   wr_cycles,
  input  logic [reg_width-1:0]   r_count,
  input  logic [reg_width-1:0]   w_count,
  input  logic [reg_width-1:0]   ar_count,
  input  logic [reg_width-1:0]   aw_count,
  output logic [reg_width-1:0]   reg_rdata,
  output logic                   reg_rvalid,
  output logic                   go,
  output logic [addr_width-1:0]  rd_base,
  output logic [addr_width-1:0]  wr_base,
  output logic [size_width-1:0]  size
);

  logic                 busy;
  logic                 done;                       // sticky until next go
  logic [reg_width-1:0] status_word;

  always_comb
  begin
    status_word                  = '0;
    status_word[status_busy_bit] = busy;
    status_word[status_done_bit] = done;
  end

  // ------------------------------------------------------------
  // write side
  // ------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      go      <= 1'b0;
      size    <= '0;
      rd_base <= '0;
      wr_base <= '0;
    end
    else
    begin
      go <= reg_wr && (reg_addr == reg_ctrl) && reg_wdata[ctrl_go_bit];
      if (reg_wr)
        case (reg_addr)
          reg_size:    size    <= reg_wdata[size_width-1:0];
          reg_rd_base: rd_base <= reg_wdata;
          reg_wr_base: wr_base <= reg_wdata;
          default:     ;
        endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      busy <= 1'b0;
      done <= 1'b0;
    end
    else if (go)
    begin
      busy <= 1'b1;
      done <= 1'b0;
    end
    else if (xfer_done)
    begin
      busy <= 1'b0;
      done <= 1'b1;
    end
  end

  // ------------------------------------------------------------
  // readback, one cycle after reg_rd
  // ------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!resetn)
      reg_rvalid <= 1'b0;
    else
      reg_rvalid <= reg_rd;
  end

  always_ff @(posedge clk)
  begin
    if (reg_rd)
      case (reg_addr)
        reg_ctrl:         reg_rdata <= status_word;
        reg_size:         reg_rdata <= reg_width'(size);
        reg_rd_base:      reg_rdata <= rd_base;
        reg_wr_base:      reg_rdata <= wr_base;
        reg_total_cycles: reg_rdata <= total_cycles;
        reg_rd_cycles:    reg_rdata <= rd_cycles;
        reg_wr_cycles:    reg_rdata <= wr_cycles;
        reg_r_count:      reg_rdata <= r_count;
        reg_w_count:      reg_rdata <= w_count;
        reg_ar_count:     reg_rdata <= ar_count;
        reg_aw_count:     reg_rdata <= aw_count;
        default:          reg_rdata <= '0;          // unmapped
      endcase
  end

  // busy drops only on the writer's final response
  a_go_idle: assert property (@(posedge clk) disable iff (!resetn) go |-> !busy);

endmodule

//--- verilog/loopback_top.sv
`timescale 1ns/1ps

module loopback_top import loopback_pkg::*; #(
  parameter int fifo_addr_width = 6
) (
  input  logic                   clk,
  input  logic                   resetn,
  input  logic [addr_width-1:0]  reg_addr,
  input  logic [reg_width-1:0]   reg_wdata,
  input  logic                   reg_wr,
  input  logic                   reg_rd,
  output logic [reg_width-1:0]   reg_rdata,
  output logic                   reg_rvalid,
  output logic [addr_width-1:0]  ar_addr,
  output logic                   ar_valid,
  input  logic                   ar_ready,
  input  logic [data_width-1:0]  r_data,
  input  logic                   r_last,
  input  logic                   r_valid,
  output logic                   r_ready,
  output logic [addr_width-1:0]  aw_addr,
  output logic                   aw_valid,
  input  logic                   aw_ready,
  output logic [data_width-1:0]  w_data,
  output logic                   w_last,
  output logic                   w_valid,
  input  logic                   w_ready,
  input  logic                   b_valid,
  output logic                   b_ready
);

  logic                     go;
  logic                     xfer_done;
  logic [addr_width-1:0]    rd_base;
  logic [addr_width-1:0]    wr_base;
  logic [size_width-1:0]    size;
  logic                     push;
  logic [data_width-1:0]    push_data;
  logic                     pop;
  logic [data_width-1:0]    pop_data;
  logic [fifo_addr_width:0] count;
  logic [reg_width-1:0]     total_cycles;
  logic [reg_width-1:0]     rd_cycles;
  logic [reg_width-1:0]     wr_cycles;
  logic [reg_width-1:0]     r_count;
  logic [reg_width-1:0]     w_count;
  logic [reg_width-1:0]     ar_count;
  logic [reg_width-1:0]     aw_count;

  ctrl_regs u_regs (
    .clk, .resetn, .reg_addr, .reg_wdata, .reg_wr, .reg_rd, .xfer_done,
    .total_cycles, .rd_cycles, .wr_cycles, .r_count, .w_count, .ar_count, .aw_count,
    .reg_rdata, .reg_rvalid, .go, .rd_base, .wr_base, .size
  );

  // ------------------------------------------------------------
  // mover: reader, buffer, writer
  // ------------------------------------------------------------
  burst_reader #(.fifo_addr_width(fifo_addr_width)) u_reader (
    .clk, .resetn, .go, .rd_base, .size, .count,
    .ar_ready, .r_data, .r_last, .r_valid,
    .ar_addr, .ar_valid, .r_ready, .push, .push_data
  );

  sync_fifo #(
    .data_width      (data_width),
    .fifo_addr_width (fifo_addr_width)
  ) u_fifo (
    .clk, .resetn, .push, .push_data, .pop, .pop_data,
    .empty (),                                      // writer works from count
    .full  (),
    .count
  );

  burst_writer #(.fifo_addr_width(fifo_addr_width)) u_writer (
    .clk, .resetn, .go, .wr_base, .size, .count, .pop_data,
    .aw_ready, .w_ready, .b_valid,
    .pop, .aw_addr, .aw_valid, .w_data, .w_last, .w_valid, .b_ready, .xfer_done
  );

  perf_monitor u_perf (
    .clk, .resetn, .go, .xfer_done,
    .ar_valid, .ar_ready, .r_valid, .r_ready, .r_last,
    .aw_valid, .aw_ready, .w_valid, .w_ready, .w_last, .b_valid, .b_ready,
    .total_cycles, .rd_cycles, .wr_cycles, .r_count, .w_count, .ar_count, .aw_count
  );

endmodule

//--- tb/mem_model.sv
`timescale 1ns/1ps

module mem_model import loopback_pkg::*; (
  input  logic                   clk,
  input  logic                   resetn,
  input  logic [addr_width-1:0]  ar_addr,
  input  logic                   ar_valid,
  output logic                   ar_ready,
  output logic [data_width-1:0]  r_data,
  output logic                   r_last,
  output logic                   r_valid,
  input  logic                   r_ready,
  input  logic [addr_width-1:0]  aw_addr,
  input  logic                   aw_valid,
  output logic                   aw_ready,
  input  logic [data_width-1:0]  w_data,
  input  logic                   w_last,
  input  logic                   w_valid,
  output logic                   w_ready,
  output logic                   b_valid,
  input  logic                   b_ready
);

  integer                seed;
  int                    wlast_errors;              // w_last off the 16th beat
  logic [data_width-1:0] store [0:4095];            // write window, addr[14:3]
  logic                  rd_busy;
  logic                  wr_busy;
  logic                  b_pending;
  logic [addr_width-1:0] rd_addr;
  logic [addr_width-1:0] wr_addr;
  logic [addr_width-1:0] beat_addr;
  int                    rd_beat;
  int                    wr_beat;
  logic                  ar_fire;
  logic                  r_fire;
  logic                  aw_fire;
  logic                  w_fire;
  logic                  b_fire;

  // source region contents, a function of the full byte address
  function automatic logic [data_width-1:0] source_word(input logic [addr_width-1:0] addr);
    return {addr ^ 32'h3c5a_96e1, ~addr};
  endfunction

  function automatic logic roll_ready();
    return ($random(seed) % 4) != 0;                // ready about three cycles in four
  endfunction

  initial
  begin
    seed         = 32'hf79c4315;
    wlast_errors = 0;
    ar_ready     = 1'b0;
    r_valid      = 1'b0;
    r_data       = '0;
    r_last       = 1'b0;
    aw_ready     = 1'b0;
    w_ready      = 1'b0;
    b_valid      = 1'b0;
    rd_busy      = 1'b0;
    wr_busy      = 1'b0;
    b_pending    = 1'b0;
    rd_addr      = '0;
    wr_addr      = '0;
    rd_beat      = 0;
    wr_beat      = 0;
    forever
    begin
      @(posedge clk);
      ar_fire = ar_valid && ar_ready;
      r_fire  = r_valid && r_ready;
      aw_fire = aw_valid && aw_ready;
      w_fire  = w_valid && w_ready;
      b_fire  = b_valid && b_ready;
      if (!resetn)
      begin
        rd_busy   = 1'b0;
        wr_busy   = 1'b0;
        b_pending = 1'b0;
      end
      else
      begin
        // ----------------------------------------------------------
        // read side, one burst at a time
        // ----------------------------------------------------------
        if (ar_fire)
        begin
          rd_busy = 1'b1;
          rd_addr = ar_addr;
          rd_beat = 0;
        end
        if (r_fire)
        begin
          rd_beat = rd_beat + 1;
          if (r_last)
            rd_busy = 1'b0;
        end
        // ----------------------------------------------------------
        // write side, data then response
        // ----------------------------------------------------------
        if (aw_fire)
        begin
          wr_busy = 1'b1;
          wr_addr = aw_addr;
          wr_beat = 0;
        end
        if (w_fire)
        begin
          beat_addr = wr_addr + addr_width'(8 * wr_beat);
          store[beat_addr[14:3]] = w_data;
          if (w_last != (wr_beat == burst_len - 1))
            wlast_errors = wlast_errors + 1;
          wr_beat = wr_beat + 1;
          if (w_last)
          begin
            wr_busy   = 1'b0;
            b_pending = 1'b1;
          end
        end
        if (b_fire)
          b_pending = 1'b0;
      end
      #2;
      ar_ready = !rd_busy && roll_ready();
      aw_ready = !wr_busy && !b_pending && roll_ready();
      w_ready  = wr_busy && roll_ready();
      if (!rd_busy || r_fire || !r_valid)           // a stalled beat holds
      begin
        r_valid = rd_busy && roll_ready();
        r_data  = source_word(rd_addr + addr_width'(8 * rd_beat));
        r_last  = rd_busy && (rd_beat == burst_len - 1);
      end
      if (!b_pending || b_fire || !b_valid)
        b_valid = b_pending && roll_ready();
    end
  end

endmodule

//--- tb/tb_loopback.sv
`timescale 1ns/1ps

module tb_loopback import loopback_pkg::*; ();

  localparam int clk_period       = 40;
  localparam int num_runs         = 3;
  localparam int total_bursts     = 12;             // 1 + 3 + 8
  localparam int cycles_per_burst = 200;
  localparam int margin_cycles    = 500;

  logic                  clk;
  logic                  resetn;
  logic [addr_width-1:0] reg_addr;
  logic [reg_width-1:0]  reg_wdata;
  logic                  reg_wr;
  logic                  reg_rd;
  logic [reg_width-1:0]  reg_rdata;
  logic                  reg_rvalid;
  logic [addr_width-1:0] ar_addr;
  logic                  ar_valid;
  logic                  ar_ready;
  logic [data_width-1:0] r_data;
  logic                  r_last;
  logic                  r_valid;
  logic                  r_ready;
  logic [addr_width-1:0] aw_addr;
  logic                  aw_valid;
  logic                  aw_ready;
  logic [data_width-1:0] w_data;
  logic                  w_last;
  logic                  w_valid;
  logic                  w_ready;
  logic                  b_valid;
  logic                  b_ready;

  int                    run_sizes [0:num_runs-1] = '{1, 3, 8};
  logic [addr_width-1:0] rd_bases [0:num_runs-1]  = '{32'h0001_0000, 32'h0002_0400, 32'h0003_1000};
  logic [addr_width-1:0] wr_bases [0:num_runs-1]  = '{32'h0008_0000, 32'h0008_2000, 32'h0009_4000};

  logic [addr_width-1:0] ar_log [$];                // accepted read burst addresses
  logic [addr_width-1:0] aw_log [$];
  logic [reg_width-1:0]  cur_size;
  logic [addr_width-1:0] cur_rd_base;
  logic [addr_width-1:0] cur_wr_base;
  logic [reg_width-1:0]  status;
  logic [reg_width-1:0]  reg_value;
  logic [reg_width-1:0]  final_status;
  logic [reg_width-1:0]  tot_cyc;
  logic [reg_width-1:0]  rd_cyc;
  logic [reg_width-1:0]  wr_cyc;
  logic [reg_width-1:0]  r_cnt;
  logic [reg_width-1:0]  w_cnt;
  logic [reg_width-1:0]  ar_cnt;
  logic [reg_width-1:0]  aw_cnt;
  logic [addr_width-1:0] dst;
  event                  check_req;
  int                    checks_done;

  loopback_top #(.fifo_addr_width(6)) u_dut (
    .clk, .resetn, .reg_addr, .reg_wdata, .reg_wr, .reg_rd, .reg_rdata, .reg_rvalid,
    .ar_addr, .ar_valid, .ar_ready, .r_data, .r_last, .r_valid, .r_ready,
    .aw_addr, .aw_valid, .aw_ready, .w_data, .w_last, .w_valid, .w_ready,
    .b_valid, .b_ready
  );

  mem_model u_mem (
    .clk, .resetn, .ar_addr, .ar_valid, .ar_ready, .r_data, .r_last, .r_valid, .r_ready,
    .aw_addr, .aw_valid, .aw_ready, .w_data, .w_last, .w_valid, .w_ready,
    .b_valid, .b_ready
  );

  initial
  begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // source word expected at a given beat index from a read base
  function automatic logic [data_width-1:0] expected_word(input logic [addr_width-1:0] base,
                                                         input int index);
    logic [addr_width-1:0] addr;
    addr = base + addr_width'(index * 8);
    return {addr ^ 32'h3c5a_96e1, ~addr};
  endfunction

  // ------------------------------------------------------------
  // check and register helpers
  // ------------------------------------------------------------
  task automatic report_failure(input string msg);
    $display("Fail at %0t ns: %s", $time, msg);
    $display("TEST FAIL");
  endtask

  task automatic expect_equal(input string what, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp)
    else
    begin
      report_failure($sformatf("%s is %0h, expected %0h", what, got, exp));
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic expect_true(input string what, input logic cond);
    assert (cond === 1'b1)
    else
    begin
      report_failure($sformatf("%s does not hold", what));
      $fatal(1, "condition failed");
    end
  endtask

  task automatic write_reg(input int addr, input logic [reg_width-1:0] data);
    reg_addr  = addr_width'(addr);
    reg_wdata = data;
    reg_wr    = 1'b1;
    @(posedge clk);
    #2;
    reg_wr = 1'b0;
  endtask

  task automatic read_reg(input int addr, output logic [reg_width-1:0] data);
    reg_addr = addr_width'(addr);
    reg_rd   = 1'b1;
    @(posedge clk);
    #2;
    reg_rd = 1'b0;
    expect_true($sformatf("reg_rvalid one cycle after reading register %0d", addr), reg_rvalid);
    data = reg_rdata;
  endtask

  always @(posedge clk)
  begin
    if (resetn && ar_valid && ar_ready)
      ar_log.push_back(ar_addr);
    if (resetn && aw_valid && aw_ready)
      aw_log.push_back(aw_addr);
  end

  // ------------------------------------------------------------
  // compare process, one pass per finished transfer
  // ------------------------------------------------------------
  always @(check_req)
  begin
    expect_true("done without busy at the end", final_status[status_done_bit]
                && !final_status[status_busy_bit]);
    expect_equal("ar_count", ar_cnt, cur_size);
    expect_equal("aw_count", aw_cnt, cur_size);
    expect_equal("r_count", r_cnt, burst_len * cur_size);
    expect_equal("w_count", w_cnt, burst_len * cur_size);
    expect_true("rd_cycles nonzero", rd_cyc != 0);
    expect_true("wr_cycles nonzero", wr_cyc != 0);
    expect_true("rd_cycles within total_cycles", rd_cyc <= tot_cyc);
    expect_true("wr_cycles within total_cycles", wr_cyc <= tot_cyc);
    expect_equal("read bursts seen", ar_log.size(), cur_size);
    expect_equal("write bursts seen", aw_log.size(), cur_size);
    for (int i = 0; i < ar_log.size(); i++)
      expect_equal($sformatf("read burst %0d address", i), ar_log[i],
                   cur_rd_base + addr_width'(burst_bytes * i));
    for (int i = 0; i < aw_log.size(); i++)
      expect_equal($sformatf("write burst %0d address", i), aw_log[i],
                   cur_wr_base + addr_width'(burst_bytes * i));
    expect_equal("w_last framing errors", u_mem.wlast_errors, 0);
    for (int i = 0; i < burst_len * cur_size; i++)
    begin
      dst = cur_wr_base + addr_width'(8 * i);
      expect_equal($sformatf("word %0d at %0h", i, dst), u_mem.store[dst[14:3]],
                   expected_word(cur_rd_base, i));
    end
    checks_done = checks_done + 1;
  end

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------
  initial
  begin
    resetn      = 1'b0;
    reg_addr    = '0;
    reg_wdata   = '0;
    reg_wr      = 1'b0;
    reg_rd      = 1'b0;
    checks_done = 0;
    repeat (4) @(posedge clk);
    #2;
    resetn = 1'b1;
    @(posedge clk);
    #2;
    for (int run = 0; run < num_runs; run++)
    begin
      cur_size    = reg_width'(run_sizes[run]);
      cur_rd_base = rd_bases[run];
      cur_wr_base = wr_bases[run];
      write_reg(reg_size, cur_size);
      write_reg(reg_rd_base, cur_rd_base);
      write_reg(reg_wr_base, cur_wr_base);
      read_reg(reg_size, reg_value);
      expect_equal("size readback", reg_value, cur_size);
      read_reg(reg_rd_base, reg_value);
      expect_equal("rd_base readback", reg_value, cur_rd_base);
      read_reg(reg_wr_base, reg_value);
      expect_equal("wr_base readback", reg_value, cur_wr_base);
      ar_log.delete();
      aw_log.delete();
      write_reg(reg_ctrl, reg_width'(1) << ctrl_go_bit);
      @(posedge clk);                               // go reaches busy
      #2;
      read_reg(reg_ctrl, status);
      expect_true("busy without done after go", status[status_busy_bit]
                  && !status[status_done_bit]);
      read_reg(reg_aw_count, reg_value);
      expect_equal("aw_count just after go", reg_value, 0);
      read_reg(reg_w_count, reg_value);
      expect_equal("w_count just after go", reg_value, 0);
      do
        read_reg(reg_ctrl, status);
      while (!status[status_done_bit]);
      final_status = status;
      read_reg(reg_total_cycles, tot_cyc);
      read_reg(reg_rd_cycles, rd_cyc);
      read_reg(reg_wr_cycles, wr_cyc);
      read_reg(reg_r_count, r_cnt);
      read_reg(reg_w_count, w_cnt);
      read_reg(reg_ar_count, ar_cnt);
      read_reg(reg_aw_count, aw_cnt);
      -> check_req;
      wait (checks_done == run + 1);
    end
    $display("TEST PASS");
    $finish;
  end

  initial
  begin
    #((total_bursts * cycles_per_burst + margin_cycles) * clk_period);
    $display("Error: the transfer never finished within %0d cycles",
             total_bursts * cycles_per_burst + margin_cycles);
    $display("TEST FAIL");
    $fatal(1, "watchdog timeout");
  end

endmodule

//--- vlog.f
verilog/loopback_pkg.sv
verilog/sync_fifo.sv
verilog/burst_reader.sv
verilog/burst_writer.sv
verilog/perf_monitor.sv
verilog/ctrl_regs.sv
verilog/loopback_top.sv
tb/mem_model.sv
tb/tb_loopback.sv
